// ==== common/tsconf_params.svh ====
`ifndef TSCONF_PARAMS_SVH
`define TSCONF_PARAMS_SVH

// port decode
`define TS_XTPORT_LO 8'hAF
`define TS_FE_PORT 8'hFE

// im2 vectors
`define TS_IM2_FRM 8'hFF
`define TS_IM2_LIN 8'hFD

// raster timing
`define TS_LINE_CLKS 448    // fclk cycles per line
`define TS_FRAME_LINES 320
`define TS_INT_LEN 32       // max int_n width in zpos strobes

// fclk cycles per cpu clock
`define TS_DIV_3M5 8
`define TS_DIV_7M 4
`define TS_DIV_14M 2

`endif

// ==== common/tsconf_pkg.sv ====
package tsconf_pkg;

  // bus events after synchronization into fclk
  typedef struct packed {
    logic iord_s;    // start of io read
    logic iowr_s;    // start of io write
    logic intack_s;  // start of int acknowledge
    logic iord;      // level, whole read cycle
    logic intack;    // level, m1 with iorq
  } bus_strobes_t;

  typedef struct packed {
    logic [4:0] spare;
    logic       tape_sound;  // mix tape input into beeper
    logic [1:0] turbo;       // 00 3.5, 01 7, 1x 14 MHz
  } sysconf_t;

  typedef struct packed {
    logic [5:0] spare;
    logic       line;
    logic       frame;
  } intmask_t;

  // one-cycle start pulses from the raster timer
  typedef struct packed {
    logic frame;
    logic line;
  } int_src_t;

  // register number in the high address byte of #xxAF
  typedef enum logic [7:0] {
    XT_BORDER  = 8'h0F,
    XT_SYSCONF = 8'h20,
    XT_INTMASK = 8'h2A
  } xt_reg_e;

endpackage

// ==== verilog/zbus_sync.sv ====
module zbus_sync (
  input  logic                     fclk,
  input  logic                     reset,
  input  logic                     iorq_n,
  input  logic                     rd_n,
  input  logic                     wr_n,
  input  logic                     m1_n,
  output tsconf_pkg::bus_strobes_t strobes
);

  logic [3:0] sync1;
  logic [3:0] sync2;
  logic       iorq;
  logic       rd;
  logic       wr;
  logic       m1;
  logic       iord_c;
  logic       iowr_c;
  logic       intack_c;
  logic       iowr_q;

  always_ff @(posedge fclk) begin
    if (reset) begin
      sync1 <= 4'hF;  // idle bus
      sync2 <= 4'hF;
    end else begin
      sync1 <= {iorq_n, rd_n, wr_n, m1_n};
      sync2 <= sync1;
    end
  end

  assign {iorq, rd, wr, m1} = ~sync2;

  assign iord_c   = iorq & rd & ~m1;
  assign iowr_c   = iorq & wr & ~m1;
  assign intack_c = iorq & m1;  // m1 with iorq, no rd in that cycle

  always_ff @(posedge fclk) begin
    if (reset) begin
      strobes <= '0;
      iowr_q  <= 1'b0;
    end else begin
      strobes.iord_s   <= iord_c & ~strobes.iord;
      strobes.iowr_s   <= iowr_c & ~iowr_q;
      strobes.intack_s <= intack_c & ~strobes.intack;
      strobes.iord     <= iord_c;
      strobes.intack   <= intack_c;
      iowr_q           <= iowr_c;
    end
  end

  a_rd_wr_excl : assert property (@(posedge fclk) disable iff (reset)
    !(strobes.iord_s && strobes.iowr_s));

endmodule

// ==== verilog/zclock_div.sv ====
`include "tsconf_params.svh"

module zclock_div (
  input  logic                 fclk,
  input  logic                 reset,
  input  tsconf_pkg::sysconf_t sysconf,
  output logic                 clkz_out,
  output logic                 zpos,
  output logic                 zneg
);

  logic [3:0] ratio;      // ratio of the running period
  logic [3:0] ratio_nxt;
  logic [3:0] cnt;

  always_comb begin
    case (sysconf.turbo)
      2'b00:   ratio_nxt = 4'(`TS_DIV_3M5);
      2'b01:   ratio_nxt = 4'(`TS_DIV_7M);
      default: ratio_nxt = 4'(`TS_DIV_14M);  // 11 runs at 14 MHz too
    endcase
  end

  // strobes mark the cycle before the clkz_out edge
  assign zpos = cnt == ratio - 4'd1;
  assign zneg = cnt == (ratio >> 1) - 4'd1;

  always_ff @(posedge fclk) begin
    if (reset) begin
      cnt      <= '0;
      ratio    <= 4'(`TS_DIV_3M5);
      clkz_out <= 1'b0;
    end else begin
      if (zpos) begin
        cnt   <= '0;
        ratio <= ratio_nxt;  // only at period wrap, no runt pulse
      end else begin
        cnt <= cnt + 4'd1;
      end
      if (zpos)
        clkz_out <= 1'b1;
      else if (zneg)
        clkz_out <= 1'b0;
    end
  end

  // each period has had its low phase before the next rise
  a_low_before_rise : assert property (@(posedge fclk) disable iff (reset)
    zpos |-> !clkz_out);

endmodule

// ==== ports/port_regs.sv ====
`include "tsconf_params.svh"

module port_regs (
  input  logic                     fclk,
  input  logic                     reset,
  input  logic [15:0]              a,
  input  logic [7:0]               din,
  input  tsconf_pkg::bus_strobes_t strobes,
  input  logic                     tape_in,
  output tsconf_pkg::sysconf_t     sysconf,
  output tsconf_pkg::intmask_t     intmask,
  output logic [7:0]               border,
  output logic [7:0]               dout,
  output logic                     dout_ena,
  output logic                     beep
);

  localparam logic [7:0] FE_PORT = `TS_FE_PORT;

  logic       xt_hit;
  logic       fe_hit;
  logic       beeper;
  logic [1:0] tape_sync;
  logic [7:0] rd_data;
  logic       rd_hit;
  logic       rd_act;

  assign xt_hit = a[7:0] == `TS_XTPORT_LO;
  assign fe_hit = a[0] == FE_PORT[0];  // partial decode, a0 only

  always_comb begin
    rd_data = 8'hFF;
    rd_hit  = 1'b0;
    if (fe_hit) begin
      rd_data = {1'b1, tape_sync[1], 6'h3F};
      rd_hit  = 1'b1;
    end else if (xt_hit) begin
      rd_hit = 1'b1;
      case (a[15:8])
        tsconf_pkg::XT_BORDER:  rd_data = border;
        tsconf_pkg::XT_SYSCONF: rd_data = sysconf;
        tsconf_pkg::XT_INTMASK: rd_data = intmask;
        default:                rd_hit  = 1'b0;  // unmapped, bus left alone
      endcase
    end
  end

  always_ff @(posedge fclk) begin
    if (reset) begin
      border  <= '0;
      sysconf <= '0;
      intmask <= 8'h01;  // frame int only
      beeper  <= 1'b0;
    end else if (strobes.iowr_s) begin
      if (fe_hit) begin
        beeper      <= din[4];
        border[2:0] <= din[2:0];
      end else if (xt_hit) begin
        case (a[15:8])
          tsconf_pkg::XT_BORDER:  border  <= din;
          tsconf_pkg::XT_SYSCONF: sysconf <= din;
          tsconf_pkg::XT_INTMASK: intmask <= din;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (reset)
      rd_act <= 1'b0;
    else if (strobes.iord_s)
      rd_act <= rd_hit;
    else if (!strobes.iord)
      rd_act <= 1'b0;
  end

  // data held for the whole read cycle
  always_ff @(posedge fclk) begin
    if (strobes.iord_s)
      dout <= rd_data;
  end

  always_ff @(posedge fclk) begin
    tape_sync <= {tape_sync[0], tape_in};
  end

  assign dout_ena = rd_act & strobes.iord;
  assign beep     = beeper ^ (sysconf.tape_sound & tape_sync[1]);

endmodule

// ==== irq/int_timer.sv ====
`include "tsconf_params.svh"

module int_timer (
  input  logic                 fclk,
  input  logic                 reset,
  output tsconf_pkg::int_src_t starts
);

  logic [8:0] col;
  logic [8:0] line_cnt;
  logic       eol;
  logic       eof;

  assign eol = col == 9'(`TS_LINE_CLKS - 1);
  assign eof = line_cnt == 9'(`TS_FRAME_LINES - 1);

  always_ff @(posedge fclk) begin
    if (reset) begin
      col      <= '0;
      line_cnt <= '0;
      starts   <= '0;
    end else begin
      starts.line  <= eol;
      starts.frame <= eol & eof;  // lands on a line pulse
      if (eol) begin
        col      <= '0;
        line_cnt <= eof ? '0 : line_cnt + 9'd1;
      end else begin
        col <= col + 9'd1;
      end
    end
  end

endmodule

// ==== irq/int_ctrl.sv ====
`include "tsconf_params.svh"

module int_ctrl (
  input  logic                     fclk,
  input  logic                     reset,
  input  tsconf_pkg::int_src_t     starts,
  input  tsconf_pkg::intmask_t     intmask,
  input  logic                     zpos,
  input  tsconf_pkg::bus_strobes_t strobes,
  output logic                     int_n,
  output logic [7:0]               im2vect
);

  logic       pend_frm;
  logic       pend_lin;
  logic       frm_go;
  logic       lin_go;
  logic       ack_frm;
  logic       ack_lin;
  logic       int_r;
  logic       vec_frm;  // vector names frame, frozen during intack
  logic [5:0] len_cnt;  // zpos strobes since int_n fell

  assign frm_go = starts.frame & intmask.frame;
  assign lin_go = starts.line & intmask.line;

  // ack goes to whatever the vector shows
  assign ack_frm = strobes.intack_s & vec_frm;
  assign ack_lin = strobes.intack_s & ~vec_frm & pend_lin;

  always_ff @(posedge fclk) begin
    if (reset) begin
      pend_frm <= 1'b0;
      pend_lin <= 1'b0;
      int_r    <= 1'b0;
      vec_frm  <= 1'b0;
      len_cnt  <= '0;
    end else begin
      pend_frm <= frm_go | (pend_frm & ~ack_frm);
      pend_lin <= lin_go | (pend_lin & ~ack_lin);
      if (!strobes.intack)
        vec_frm <= pend_frm;  // held while the cpu reads it
      if (frm_go || lin_go) begin
        int_r   <= 1'b1;
        len_cnt <= '0;
      end else if (strobes.intack_s || (zpos && len_cnt == 6'(`TS_INT_LEN - 1))) begin
        int_r <= 1'b0;  // pending stays set on timeout
      end else if (int_r && zpos) begin
        len_cnt <= len_cnt + 6'd1;
      end
    end
  end

  assign int_n   = ~int_r;
  assign im2vect = vec_frm ? `TS_IM2_FRM : `TS_IM2_LIN;

  a_int_has_src : assert property (@(posedge fclk) disable iff (reset)
    !int_n |-> (pend_frm || pend_lin));

endmodule

// ==== verilog/tsconf_io_top.sv ====
module tsconf_io_top (
  input  logic        fclk,
  input  logic        reset,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic        tape_in,
  input  logic [15:0] a,
  input  logic [7:0]  d,
  output logic [7:0]  zd_out,
  output logic        zd_oe,
  output logic        clkz_out,
  output logic        int_n,
  output logic        beep,
  output logic [7:0]  border
);

  tsconf_pkg::bus_strobes_t strobes;
  tsconf_pkg::sysconf_t     sysconf;
  tsconf_pkg::intmask_t     intmask;
  tsconf_pkg::int_src_t     starts;
  logic                     zpos;
  logic [7:0]               dout_ports;
  logic                     ena_ports;
  logic [7:0]               im2vect;

  zbus_sync i_zbus_sync (
    .fclk    (fclk),
    .reset   (reset),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .m1_n    (m1_n),
    .strobes (strobes)
  );

  zclock_div i_zclock_div (
    .fclk     (fclk),
    .reset    (reset),
    .sysconf  (sysconf),
    .clkz_out (clkz_out),
    .zpos     (zpos),
    .zneg     ()
  );

  port_regs i_port_regs (
    .fclk     (fclk),
    .reset    (reset),
    .a        (a),
    .din      (d),
    .strobes  (strobes),
    .tape_in  (tape_in),
    .sysconf  (sysconf),
    .intmask  (intmask),
    .border   (border),
    .dout     (dout_ports),
    .dout_ena (ena_ports),
    .beep     (beep)
  );

  int_timer i_int_timer (
    .fclk   (fclk),
    .reset  (reset),
    .starts (starts)
  );

  int_ctrl i_int_ctrl (
    .fclk    (fclk),
    .reset   (reset),
    .starts  (starts),
    .intmask (intmask),
    .zpos    (zpos),
    .strobes (strobes),
    .int_n   (int_n),
    .im2vect (im2vect)
  );

  // vector wins during intack
  assign zd_out = strobes.intack ? im2vect : dout_ports;
  assign zd_oe  = strobes.intack | ena_ports;

endmodule

// ==== verif/tb_tsconf_io.sv ====
`include "tsconf_params.svh"

module tb_tsconf_io;
  timeunit 1ns;
  timeprecision 1ps;

  logic        fclk;
  logic        reset;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic        tape_in;
  logic [15:0] a;
  logic [7:0]  d;
  logic [7:0]  zd_out;
  logic        zd_oe;
  logic        clkz_out;
  logic        int_n;
  logic        beep;
  logic [7:0]  border;

  // reference register state, updated after each write
  logic [7:0]           border_exp;
  tsconf_pkg::sysconf_t sysconf_exp;
  tsconf_pkg::intmask_t intmask_exp;
  logic                 beeper_exp;
  logic                 exp_beep;
  logic [7:0]           exp_data;
  logic                 exp_oe;
  int                   exp_div;

  logic        chk_idle;
  logic        chk_div;
  logic        chk_int_hi;
  logic        rd_window;   // middle of a read or intack cycle
  logic        shadow_ok;
  logic        clkz_q;
  int          since_rise;
  int          errors;
  int          timeouts;
  string       test_name;
  logic [31:0] lcg_state;

  tsconf_io_top i_dut (
    .fclk     (fclk),
    .reset    (reset),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .tape_in  (tape_in),
    .a        (a),
    .d        (d),
    .zd_out   (zd_out),
    .zd_oe    (zd_oe),
    .clkz_out (clkz_out),
    .int_n    (int_n),
    .beep     (beep),
    .border   (border)
  );

  initial begin
    fclk = 1'b0;
    forever #20 fclk = ~fclk;
  end

  // fclk cycles since the last clkz_out rise
  always @(posedge fclk) begin
    if (reset) begin
      clkz_q     <= 1'b0;
      since_rise <= 0;
    end else begin
      clkz_q     <= clkz_out;
      since_rise <= (clkz_out && !clkz_q) ? 1 : since_rise + 1;
    end
  end

  assign exp_beep = beeper_exp ^ (sysconf_exp.tape_sound & tape_in);

  task automatic report_mismatch(input string sig, input logic [31:0] expv,
                                 input logic [31:0] actv);
    errors++;
    $display("Error %s %s: expected %0h, actual %0h", test_name, sig, expv, actv);
  endtask

  a_idle_int : assert property (@(posedge fclk) disable iff (reset) chk_idle |-> int_n)
    else report_mismatch("int_n", 1, $sampled(int_n));
  a_idle_oe : assert property (@(posedge fclk) disable iff (reset) chk_idle |-> !zd_oe)
    else report_mismatch("zd_oe", 0, $sampled(zd_oe));
  a_div : assert property (@(posedge fclk) disable iff (reset)
    (chk_div && clkz_out && !clkz_q) |-> since_rise == exp_div)
    else report_mismatch("clkz_out spacing", $sampled(exp_div), $sampled(since_rise));
  a_rd_oe : assert property (@(posedge fclk) disable iff (reset) rd_window |-> zd_oe == exp_oe)
    else report_mismatch("zd_oe", $sampled(exp_oe), $sampled(zd_oe));
  a_rd_data : assert property (@(posedge fclk) disable iff (reset)
    (rd_window && exp_oe) |-> zd_out == exp_data)
    else report_mismatch("zd_out", $sampled(exp_data), $sampled(zd_out));
  a_border : assert property (@(posedge fclk) disable iff (reset)
    shadow_ok |-> border == border_exp)
    else report_mismatch("border", $sampled(border_exp), $sampled(border));
  a_beep : assert property (@(posedge fclk) disable iff (reset) shadow_ok |-> beep == exp_beep)
    else report_mismatch("beep", $sampled(exp_beep), $sampled(beep));
  a_int_hi : assert property (@(posedge fclk) disable iff (reset) chk_int_hi |-> int_n)
    else report_mismatch("int_n", 1, $sampled(int_n));

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  function automatic int div_for(input logic [1:0] turbo);
    case (turbo)
      2'b00:   return `TS_DIV_3M5;
      2'b01:   return `TS_DIV_7M;
      default: return `TS_DIV_14M;
    endcase
  endfunction

  function automatic logic [15:0] xt_addr(input tsconf_pkg::xt_reg_e rnum);
    return {rnum, `TS_XTPORT_LO};
  endfunction

  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    shadow_ok = 1'b0;
    a         = addr;
    d         = data;
    iorq_n    = 1'b0;
    wr_n      = 1'b0;
    repeat (12) @(negedge fclk);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    repeat (4) @(negedge fclk);
    if (addr[0] == 1'b0) begin  // #FE
      beeper_exp      = data[4];
      border_exp[2:0] = data[2:0];
    end else if (addr[7:0] == `TS_XTPORT_LO) begin
      case (addr[15:8])
        tsconf_pkg::XT_BORDER:  border_exp  = data;
        tsconf_pkg::XT_SYSCONF: sysconf_exp = data;
        tsconf_pkg::XT_INTMASK: intmask_exp = data;
        default: ;
      endcase
    end
    shadow_ok = 1'b1;
  endtask

  task automatic bus_cycle(input logic [15:0] addr, input logic ack, input logic oe,
                           input logic [7:0] data);
    a        = addr;
    exp_oe   = oe;
    exp_data = data;
    iorq_n   = 1'b0;
    rd_n     = ack;   // no rd during intack
    m1_n     = !ack;
    repeat (5) @(negedge fclk);
    rd_window = 1'b1;
    repeat (6) @(negedge fclk);
    rd_window = 1'b0;
    @(negedge fclk);
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    m1_n   = 1'b1;
    repeat (4) @(negedge fclk);
  endtask

  task automatic io_read(input logic [15:0] addr, input logic oe, input logic [7:0] data);
    bus_cycle(addr, 1'b0, oe, data);
  endtask

  task automatic intack_cycle(input logic [7:0] vect);
    bus_cycle(16'h0000, 1'b1, 1'b1, vect);
  endtask

  task automatic wait_rises(input int n);
    int   seen = 0;
    int   cycles = 0;
    logic prev;
    prev = clkz_out;
    while (seen < n && cycles < 64 * n) begin
      @(negedge fclk);
      cycles++;
      if (clkz_out && !prev)
        seen++;
      prev = clkz_out;
    end
    if (seen < n) begin
      timeouts++;
      $display("Timeout in %s: clkz_out stopped toggling", test_name);
    end
  endtask

  task automatic wait_int(input logic level, input int limit);
    int cycles = 0;
    while (int_n !== level && cycles < limit) begin
      @(negedge fclk);
      cycles++;
    end
    if (int_n !== level) begin
      timeouts++;
      $display("Timeout in %s: int_n did not go to %b within %0d cycles",
               test_name, level, limit);
    end
  endtask

  task automatic check_clock();
    wait_rises(2);  // let a new ratio settle
    exp_div = div_for(sysconf_exp.turbo);
    chk_div = 1'b1;
    wait_rises(4);
    chk_div = 1'b0;
  endtask

  task automatic set_tape(input logic v);
    shadow_ok = 1'b0;
    tape_in   = v;
    repeat (4) @(negedge fclk);  // tape_in synchronizer
    shadow_ok = 1'b1;
  endtask

  initial begin
    logic [7:0]           v;
    tsconf_pkg::sysconf_t sc;
    lcg_state   = 32'h226ea187;
    errors      = 0;
    timeouts    = 0;
    reset       = 1'b1;
    iorq_n      = 1'b1;
    rd_n        = 1'b1;
    wr_n        = 1'b1;
    m1_n        = 1'b1;
    tape_in     = 1'b0;
    a           = '0;
    d           = '0;
    chk_idle    = 1'b0;
    chk_div     = 1'b0;
    chk_int_hi  = 1'b0;
    rd_window   = 1'b0;
    shadow_ok   = 1'b0;
    exp_oe      = 1'b0;
    exp_data    = '0;
    exp_div     = `TS_DIV_3M5;
    border_exp  = '0;
    sysconf_exp = '0;
    intmask_exp = 8'h01;
    beeper_exp  = 1'b0;
    test_name   = "reset";
    repeat (16) @(posedge fclk);
    @(negedge fclk);
    reset     = 1'b0;
    shadow_ok = 1'b1;

    test_name = "reset_state";
    chk_idle  = 1'b1;
    check_clock();
    chk_idle = 1'b0;

    test_name = "turbo";
    for (int t = 1; t < 4; t++) begin
      io_write(xt_addr(tsconf_pkg::XT_SYSCONF), 8'(t));
      check_clock();
    end

    test_name = "reg_rw";
    io_write(xt_addr(tsconf_pkg::XT_BORDER), next_rand());
    io_write(xt_addr(tsconf_pkg::XT_SYSCONF), next_rand());
    io_write(xt_addr(tsconf_pkg::XT_INTMASK), next_rand());
    io_read(xt_addr(tsconf_pkg::XT_BORDER), 1'b1, border_exp);
    io_read(xt_addr(tsconf_pkg::XT_SYSCONF), 1'b1, sysconf_exp);
    io_read(xt_addr(tsconf_pkg::XT_INTMASK), 1'b1, intmask_exp);
    io_read({8'h55, `TS_XTPORT_LO}, 1'b0, 8'h00);  // unmapped

    test_name = "port_fe";
    io_write(xt_addr(tsconf_pkg::XT_SYSCONF), 8'h00);
    v = next_rand();
    io_write(16'h00FE, {3'b000, 1'b1, 1'b0, v[2:0]});  // beeper on
    sc            = '0;
    sc.tape_sound = 1'b1;
    io_write(xt_addr(tsconf_pkg::XT_SYSCONF), sc);
    set_tape(1'b1);
    io_read(16'h00FE, 1'b1, {1'b1, tape_in, 6'h3F});
    set_tape(1'b0);
    io_read(16'h00FE, 1'b1, {1'b1, tape_in, 6'h3F});
    io_write(xt_addr(tsconf_pkg::XT_SYSCONF), 8'h00);

    test_name = "frame_int";
    io_write(xt_addr(tsconf_pkg::XT_INTMASK), 8'h01);
    wait_int(1'b1, `TS_INT_LEN * `TS_DIV_3M5 + 64);  // leftover line int
    wait_int(1'b0, `TS_LINE_CLKS * `TS_FRAME_LINES + 1000);
    intack_cycle(`TS_IM2_FRM);
    chk_int_hi = 1'b1;
    repeat (20) @(negedge fclk);
    chk_int_hi = 1'b0;

    test_name = "line_int";
    io_write(xt_addr(tsconf_pkg::XT_INTMASK), 8'h02);
    wait_int(1'b0, `TS_LINE_CLKS + 64);
    intack_cycle(`TS_IM2_LIN);
    io_write(xt_addr(tsconf_pkg::XT_INTMASK), 8'h00);
    chk_int_hi = 1'b1;
    repeat (`TS_LINE_CLKS * `TS_FRAME_LINES + 100) @(negedge fclk);
    chk_int_hi = 1'b0;

    repeat (4) @(negedge fclk);
    $display("tb_tsconf_io: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial begin
    repeat (400000) @(posedge fclk);
    $display("Watchdog expired, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+common
common/tsconf_pkg.sv
verilog/zbus_sync.sv
verilog/zclock_div.sv
ports/port_regs.sv
irq/int_timer.sv
irq/int_ctrl.sv
verilog/tsconf_io_top.sv
verif/tb_tsconf_io.sv

// ==== Bender.yml ====
package:
  name: tsconf_io

export_include_dirs:
  - common

sources:
  - common/tsconf_pkg.sv
  - verilog/zbus_sync.sv
  - verilog/zclock_div.sv
  - ports/port_regs.sv
  - irq/int_timer.sv
  - irq/int_ctrl.sv
  - verilog/tsconf_io_top.sv
  - target: test
    files:
      - verif/tb_tsconf_io.sv
